// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tb_open_list_sorter -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation passed" &&
echo "run_sim: PASS" ||
{ echo "run_sim: FAIL"; exit 1; }

// ==== src/bubble_sort_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module bubble_sort_ctrl
(
	input wire logic Clk,
	input wire logic Reset,
	input wire logic start,
	input wire logic clear,
	input wire sort_ctrl_pkg::list_count_t fill_count,
	input wire path_geom_pkg::cost_t cost_a,
	input wire path_geom_pkg::cost_t cost_b,
	output sort_ctrl_pkg::list_idx_t pair_index,
	output logic swap,
	output logic busy,
	output logic done
);

	import sort_ctrl_pkg::*;

	localparam list_count_t min_sortable = list_count_t'(2);

	sort_state_t state;
	sort_state_t state_next;

	list_count_t last_pair;
	logic at_last_pair;
	logic too_short;
	logic out_of_order;
	logic swapped; // any exchange in the current pass

	////////////////////////////////////////
	// pass bookkeeping
	////////////////////////////////////////

	assign too_short = (fill_count < min_sortable);
	assign last_pair = fill_count - min_sortable;
	assign at_last_pair = (list_count_t'(pair_index) == last_pair);
	assign out_of_order = (cost_a > cost_b); // ties keep load order

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle, st_finished:
			begin
				if (start)
					state_next = st_fetch;
			end
			st_fetch:
			begin
				if (too_short)
					state_next = st_finished; // nothing to compare
				else
					state_next = st_compare; // costs registered this edge
			end
			st_compare:
			begin
				if (out_of_order)
					state_next = st_swap;
				else
					state_next = st_advance;
			end
			st_swap:
			begin
				state_next = st_advance;
			end
			st_advance:
			begin
				if (at_last_pair && !swapped)
					state_next = st_finished; // clean pass
				else
					state_next = st_fetch;
			end
			default:
			begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
			state <= st_idle;
		else if (clear)
			state <= st_idle; // abort and drop done
		else
			state <= state_next;
	end

	////////////////////////////////////////
	// pair index and swap flag
	////////////////////////////////////////

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			pair_index <= '0;
			swapped <= 1'b0;
		end
		else if (clear || ((state == st_idle || state == st_finished) && start))
		begin
			pair_index <= '0;
			swapped <= 1'b0;
		end
		else if (state == st_compare && out_of_order)
		begin
			swapped <= 1'b1;
		end
		else if (state == st_advance)
		begin
			if (at_last_pair)
			begin
				pair_index <= '0; // wrap for the next pass
				swapped <= 1'b0;
			end
			else
			begin
				pair_index <= pair_index + list_idx_t'(1);
			end
		end
	end

	////////////////////////////////////////
	// outputs
	////////////////////////////////////////

	assign swap = (state == st_swap);
	assign busy = (state != st_idle) && (state != st_finished);
	assign done = (state == st_finished); // held until start or clear

endmodule

`default_nettype wire

// ==== src/node_store.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "path_settings.svh"

module node_store
(
	input wire logic Clk,
	input wire logic Reset,
	input wire logic clear,
	input wire logic load_valid,
	input wire path_geom_pkg::node_t load_node,
	input wire logic busy,
	input wire sort_ctrl_pkg::list_idx_t pair_index,
	input wire logic swap,
	input wire sort_ctrl_pkg::list_idx_t rd_index,
	output path_geom_pkg::node_t node_a,
	output path_geom_pkg::node_t node_b,
	output path_geom_pkg::node_t rd_node,
	output sort_ctrl_pkg::list_count_t fill_count
);

	import path_geom_pkg::*;
	import sort_ctrl_pkg::*;

	localparam list_count_t full_count = list_count_t'(`LIST_DEPTH);

	node_t nodes [`LIST_DEPTH];

	list_idx_t pair_next;
	list_idx_t fill_idx;
	logic list_full;
	logic do_append;

	////////////////////////////////////////
	// append control
	////////////////////////////////////////

	assign list_full = (fill_count == full_count);
	assign fill_idx = list_idx_t'(fill_count); // only used below full
	assign do_append = load_valid && !busy && !list_full && !clear;

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
			fill_count <= '0;
		else if (clear)
			fill_count <= '0; // entries stay, count forgets them
		else if (do_append)
			fill_count <= fill_count + list_count_t'(1);
	end

	////////////////////////////////////////
	// storage
	////////////////////////////////////////

	assign pair_next = pair_index + list_idx_t'(1);

	always_ff @(posedge Clk)
	begin
		if (swap)
		begin
			nodes[pair_index] <= node_b; // exchange neighbours
			nodes[pair_next] <= node_a;
		end
		else if (do_append)
		begin
			nodes[fill_idx] <= load_node;
		end
	end

	////////////////////////////////////////
	// read ports
	////////////////////////////////////////

	assign node_a = nodes[pair_index];
	assign node_b = nodes[pair_next];
	assign rd_node = nodes[rd_index]; // host read-back

endmodule

`default_nettype wire

// ==== src/octile_cost.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "path_settings.svh"

module octile_cost
(
	input wire logic Clk,
	input wire logic Reset,
	input wire path_geom_pkg::node_t node,
	input wire path_geom_pkg::search_cfg_t cfg,
	output path_geom_pkg::cost_t cost
);

	import path_geom_pkg::*;

	localparam cost_t straight_w = cost_t'(`STRAIGHT_STEP);
	localparam cost_t diag_w = cost_t'(`DIAG_STEP);

	cost_t dist_start;
	cost_t dist_goal;

	// diagonal steps cover the shorter axis, straight steps the rest
	function automatic cost_t octile_dist(input node_t a, input node_t b);
		coord_t dx;
		coord_t dy;
		coord_t lo;
		coord_t hi;

		dx = (a.x > b.x) ? a.x - b.x : b.x - a.x;
		dy = (a.y > b.y) ? a.y - b.y : b.y - a.y;

		if (dx < dy)
		begin
			lo = dx;
			hi = dy;
		end
		else
		begin
			lo = dy;
			hi = dx;
		end

		return diag_w * cost_t'(lo) + straight_w * cost_t'(hi - lo);
	endfunction

	////////////////////////////////////////
	// distance terms
	////////////////////////////////////////

	always_comb
	begin
		dist_start = octile_dist(node, cfg.start_node);
		dist_goal = octile_dist(node, cfg.goal_node);
	end

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
			cost <= '0;
		else
			cost <= dist_start + dist_goal; // valid one cycle after node
	end

endmodule

`default_nettype wire

// ==== src/open_list_sorter_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module open_list_sorter_top
(
	input wire logic Clk,
	input wire logic Reset,
	input wire path_geom_pkg::search_cfg_t cfg,
	input wire logic clear,
	input wire logic load_valid,
	input wire path_geom_pkg::node_t load_node,
	input wire logic start,
	input wire sort_ctrl_pkg::list_idx_t rd_index,
	output path_geom_pkg::node_t rd_node,
	output logic busy,
	output logic done
);

	import path_geom_pkg::*;
	import sort_ctrl_pkg::*;

	node_t node_a;
	node_t node_b;
	cost_t cost_a;
	cost_t cost_b;
	list_idx_t pair_index;
	list_count_t fill_count;
	logic swap;

	////////////////////////////////////////
	// open list storage
	////////////////////////////////////////

	node_store store
	(
		.Clk(Clk),
		.Reset(Reset),
		.clear(clear),
		.load_valid(load_valid),
		.load_node(load_node),
		.busy(busy),
		.pair_index(pair_index),
		.swap(swap),
		.rd_index(rd_index),
		.node_a(node_a),
		.node_b(node_b),
		.rd_node(rd_node),
		.fill_count(fill_count)
	);

	////////////////////////////////////////
	// cost of each node in the pair
	////////////////////////////////////////

	octile_cost cost_a_unit
	(
		.Clk(Clk),
		.Reset(Reset),
		.node(node_a),
		.cfg(cfg),
		.cost(cost_a)
	);

	octile_cost cost_b_unit
	(
		.Clk(Clk),
		.Reset(Reset),
		.node(node_b),
		.cfg(cfg),
		.cost(cost_b)
	);

	////////////////////////////////////////
	// sort sequencing
	////////////////////////////////////////

	bubble_sort_ctrl ctrl
	(
		.Clk(Clk),
		.Reset(Reset),
		.start(start),
		.clear(clear),
		.fill_count(fill_count),
		.cost_a(cost_a),
		.cost_b(cost_b),
		.pair_index(pair_index),
		.swap(swap),
		.busy(busy),
		.done(done)
	);

endmodule

`default_nettype wire

// ==== src/path_geom_pkg.sv ====
`default_nettype none

`include "path_settings.svh"

package path_geom_pkg;

	////////////////////////////////////////
	// coordinates and nodes
	////////////////////////////////////////

	typedef logic [`COORD_W-1:0] coord_t;

	typedef struct packed
	{
		coord_t x;
		coord_t y;
	} node_t; // x in the upper byte

	////////////////////////////////////////
	// cost and search setup
	////////////////////////////////////////

	typedef logic [`COST_W-1:0] cost_t; // weighted octile sum

	typedef struct packed
	{
		node_t start_node;
		node_t goal_node;
	} search_cfg_t;

endpackage

`default_nettype wire

// ==== src/path_settings.svh ====
`ifndef PATH_SETTINGS_SVH
`define PATH_SETTINGS_SVH

////////////////////////////////////////
// grid geometry
////////////////////////////////////////

`define COORD_W 8 // bits per axis
`define COST_W 16 // start plus goal distance fits easily

////////////////////////////////////////
// open list
////////////////////////////////////////

`define LIST_DEPTH 16 // entries held by the sorter

////////////////////////////////////////
// octile step weights
////////////////////////////////////////

`define STRAIGHT_STEP 10 // one orthogonal move
`define DIAG_STEP 14 // one diagonal move, about 10 * sqrt(2)

`endif

// ==== src/sort_ctrl_pkg.sv ====
`default_nettype none

`include "path_settings.svh"

package sort_ctrl_pkg;

	typedef logic [$clog2(`LIST_DEPTH)-1:0] list_idx_t; // 0 to depth-1
	typedef logic [$clog2(`LIST_DEPTH+1)-1:0] list_count_t; // 0 to depth inclusive

	// one pair per fetch/compare/(swap)/advance round
	typedef enum logic [2:0]
	{
		st_idle,
		st_fetch,
		st_compare,
		st_swap,
		st_advance,
		st_finished
	} sort_state_t;

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/path_geom_pkg.sv
src/sort_ctrl_pkg.sv
src/node_store.sv
src/octile_cost.sv
src/bubble_sort_ctrl.sv
src/open_list_sorter_top.sv
test/open_list_sorter_properties.sv
test/tb_open_list_sorter.sv

// ==== test/open_list_sorter_properties.sv ====
`default_nettype none
`timescale 1ns/1ps

module open_list_sorter_properties
(
	input wire logic Clk,
	input wire logic Reset,
	input wire logic start,
	input wire logic clear,
	input wire logic swap,
	input wire logic busy,
	input wire logic done
);

	////////////////////////////////////////
	// controller status
	////////////////////////////////////////

	busy_done_exclusive: assert property (@(posedge Clk) disable iff (Reset)
		!(busy && done))
		else $error("busy and done are high in the same cycle");

	swap_only_busy: assert property (@(posedge Clk) disable iff (Reset)
		swap |-> busy)
		else $error("swap strobe seen while the controller is not busy");

	done_held: assert property (@(posedge Clk) disable iff (Reset)
		done && !start && !clear |=> done)
		else $error("done dropped without a start or a clear");

	start_raises_busy: assert property (@(posedge Clk) disable iff (Reset)
		start && !busy && !clear |=> busy)
		else $error("busy did not rise on the edge after start");

endmodule

bind bubble_sort_ctrl open_list_sorter_properties props
(
	.Clk(Clk),
	.Reset(Reset),
	.start(start),
	.clear(clear),
	.swap(swap),
	.busy(busy),
	.done(done)
);

`default_nettype wire

// ==== test/tb_open_list_sorter.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "path_settings.svh"

module tb_open_list_sorter;

	import path_geom_pkg::*;
	import sort_ctrl_pkg::*;

	localparam int depth = `LIST_DEPTH;
	localparam int num_random = 6;
	localparam int num_tests = num_random + 3;
	localparam int sort_limit = depth * depth * 5; // cycles for one worst-case sort
	localparam int watchdog_cycles = num_tests * sort_limit + 1000;

	logic Clk;
	logic Reset;
	search_cfg_t cfg;
	logic clear;
	logic load_valid;
	node_t load_node;
	logic start;
	list_idx_t rd_index;
	node_t rd_node;
	logic busy;
	logic done;

	int seed;
	int value_errors;
	int other_errors;
	node_t loaded_nodes [depth];
	node_t sorted_nodes [depth];
	node_t expected_nodes [7];

	open_list_sorter_top dut
	(
		.Clk(Clk),
		.Reset(Reset),
		.cfg(cfg),
		.clear(clear),
		.load_valid(load_valid),
		.load_node(load_node),
		.start(start),
		.rd_index(rd_index),
		.rd_node(rd_node),
		.busy(busy),
		.done(done)
	);

	initial
	begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge Clk);
		$display("watchdog expired before the tests completed");
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	function automatic int octile_ref(input node_t a, input node_t b);
		int dx;
		int dy;

		dx = int'(a.x) - int'(b.x);
		dy = int'(a.y) - int'(b.y);
		if (dx < 0)
			dx = -dx;
		if (dy < 0)
			dy = -dy;
		if (dx > dy)
			return `DIAG_STEP * dy + `STRAIGHT_STEP * (dx - dy); // diagonals along y
		return `DIAG_STEP * dx + `STRAIGHT_STEP * (dy - dx);
	endfunction

	function automatic int ref_cost(input node_t n);
		return octile_ref(n, cfg.start_node) + octile_ref(n, cfg.goal_node);
	endfunction

	function automatic node_t make_node(input int x, input int y);
		node_t n;

		n.x = coord_t'(x);
		n.y = coord_t'(y);
		return n;
	endfunction

	////////////////////////////////////////
	// host operations
	////////////////////////////////////////

	task automatic clear_list();
		@(posedge Clk);
		clear <= 1'b1;
		@(posedge Clk);
		clear <= 1'b0;
	endtask

	task automatic append_node(input node_t n);
		@(posedge Clk);
		load_valid <= 1'b1;
		load_node <= n;
		@(posedge Clk);
		load_valid <= 1'b0;
	endtask

	task automatic pulse_start();
		@(posedge Clk);
		start <= 1'b1;
		@(posedge Clk);
		start <= 1'b0; // seen by the controller on this edge
	endtask

	task automatic read_entry(input int idx, output node_t value);
		@(posedge Clk);
		rd_index <= list_idx_t'(idx);
		@(negedge Clk);
		value = rd_node;
	endtask

	task automatic wait_done();
		int cycles;

		cycles = 0;
		while (done !== 1'b1 && cycles < sort_limit)
		begin
			@(negedge Clk);
			cycles++;
		end
		assert (done === 1'b1)
		else
		begin
			other_errors++;
			$display("sort did not finish within %0d cycles", sort_limit);
		end
	endtask

	// stray appends while busy must be dropped by the store
	task automatic sort_and_read(input int n, input bit inject);
		pulse_start();
		if (inject)
		begin
			@(negedge Clk);
			assert (busy === 1'b1)
			else
			begin
				value_errors++;
				$display("error at %0t: busy expected 1 got %b", $time, busy);
			end
			append_node(make_node(255, 255));
			append_node(make_node(255, 254));
		end
		wait_done();
		for (int i = 0; i < n; i++)
			read_entry(i, sorted_nodes[i]);
	endtask

	////////////////////////////////////////
	// result checks
	////////////////////////////////////////

	task automatic check_order(input int n);
		for (int i = 1; i < n; i++)
		begin
			assert (ref_cost(sorted_nodes[i - 1]) <= ref_cost(sorted_nodes[i]))
			else
			begin
				value_errors++;
				$display("error at %0t: rd_node cost at index %0d expected at least %0d got %0d",
					$time, i, ref_cost(sorted_nodes[i - 1]), ref_cost(sorted_nodes[i]));
			end
		end
	endtask

	task automatic check_contents(input int n);
		bit used [depth];
		bit found;

		for (int i = 0; i < depth; i++)
			used[i] = 1'b0;
		for (int i = 0; i < n; i++)
		begin
			found = 1'b0;
			for (int j = 0; j < n; j++)
			begin
				if (!found && !used[j] && sorted_nodes[j] === loaded_nodes[i])
				begin
					used[j] = 1'b1;
					found = 1'b1;
				end
			end
			assert (found)
			else
			begin
				other_errors++;
				$display("loaded node %h is missing from the sorted list", loaded_nodes[i]);
			end
		end
	endtask

	task automatic random_test(input int n);
		logic [31:0] r;
		node_t node_before;
		node_t node_after;

		clear_list();
		r = $random(seed);
		cfg <= r;
		for (int i = 0; i < n; i++)
		begin
			r = $random(seed);
			loaded_nodes[i] = make_node(int'(r[4:0]), int'(r[12:8])); // small grid for ties
			append_node(loaded_nodes[i]);
		end
		if (n < depth)
			read_entry(n, node_before);
		sort_and_read(n, 1'b1);
		check_order(n);
		check_contents(n);
		if (n < depth)
		begin
			read_entry(n, node_after);
			assert (node_after === node_before)
			else
			begin
				value_errors++;
				$display("error at %0t: rd_node[%0d] expected %h got %h", $time, n,
					node_before, node_after);
			end
		end
	endtask

	task automatic short_test(input int n);
		node_t single;

		clear_list();
		single = make_node(7, 3);
		if (n == 1)
			append_node(single);
		pulse_start();
		@(negedge Clk);
		assert (done === 1'b0 && busy === 1'b1)
		else
		begin
			value_errors++;
			$display("error at %0t: busy/done expected 1/0 got %b/%b", $time, busy, done);
		end
		@(negedge Clk);
		assert (done === 1'b1)
		else
		begin
			value_errors++;
			$display("error at %0t: done expected 1 got %b", $time, done);
		end
		if (n == 1)
		begin
			read_entry(0, sorted_nodes[0]);
			assert (sorted_nodes[0] === single)
			else
			begin
				value_errors++;
				$display("error at %0t: rd_node[0] expected %h got %h", $time, single,
					sorted_nodes[0]);
			end
		end
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial
	begin
		seed = 32'h4568;
		value_errors = 0;
		other_errors = 0;
		Reset = 1'b1;
		cfg = '0;
		clear = 1'b0;
		load_valid = 1'b0;
		load_node = '0;
		start = 1'b0;
		rd_index = '0;
		repeat (4) @(posedge Clk);
		Reset <= 1'b0;
		@(negedge Clk);
		assert (busy === 1'b0 && done === 1'b0)
		else
		begin
			value_errors++;
			$display("error at %0t: busy/done expected 0/0 got %b/%b", $time, busy, done);
		end

		// start (0,0) and goal (4,0) give four costs of 40 that keep load order
		@(posedge Clk);
		cfg <= '{start_node: make_node(0, 0), goal_node: make_node(4, 0)};
		loaded_nodes[0] = make_node(2, 2); // 56
		loaded_nodes[1] = make_node(1, 0); // 40
		loaded_nodes[2] = make_node(5, 1); // 68
		loaded_nodes[3] = make_node(3, 0); // 40
		loaded_nodes[4] = make_node(2, 1); // 48
		loaded_nodes[5] = make_node(0, 0); // 40
		loaded_nodes[6] = make_node(2, 0); // 40
		expected_nodes = '{loaded_nodes[1], loaded_nodes[3], loaded_nodes[5], loaded_nodes[6],
			loaded_nodes[4], loaded_nodes[0], loaded_nodes[2]};
		for (int i = 0; i < 7; i++)
			append_node(loaded_nodes[i]);
		sort_and_read(7, 1'b0);
		for (int i = 0; i < 7; i++)
		begin
			assert (sorted_nodes[i] === expected_nodes[i])
			else
			begin
				value_errors++;
				$display("error at %0t: rd_node[%0d] expected %h got %h", $time, i,
					expected_nodes[i], sorted_nodes[i]);
			end
		end

		random_test(depth); // full list first
		for (int t = 1; t < num_random; t++)
			random_test(4 + int'($unsigned($random(seed)) % 13));

		short_test(0);
		short_test(1);

		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
